/* Bender.yml */
package:
  name: rfo_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rfo_pkg.sv
      - rfo_ico.sv
      - rfo_cycle_edge.sv
      - rfo_phase_meter.sv
      - rfo_pi_ctrl.sv
      - rfo_lock_detect.sv
      - rfo_dead_time.sv
      - rfo_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rfo_top.sv

/* rfo_consts.svh */
`ifndef RFO_CONSTS_SVH
`define RFO_CONSTS_SVH

// oscillator widths
`define RFO_ACC_W          24    // phase accumulator, fs = 10 MHz
`define RFO_INC_W          15    // increment, f = inc * 10e6 / 2^24
`define RFO_THETA_W        10    // signed phase count

// start point of the oscillator, used in standby and out of reset
`define RFO_START_POINT    20199

// regulator
`define RFO_THETA_TARGET   15    // small positive lead, V ahead of I
`define RFO_KI_SHIFT       1     // error gain into the integrator
`define RFO_PI_FRAC        2     // integrator fraction bits, dropped at the output

// current delay line
`define RFO_DL_DEPTH_W     8     // 256 entries
`define RFO_DL_TAP         32    // read distance behind write pointer
`define RFO_SYNC_STAGES    2     // iq synchroniser, must be 2 or more

// lock comparator with hysteresis
`define RFO_LOCK_UPPER     40    // |avg| >= 40 drops lock
`define RFO_LOCK_LOWER     16    // |avg| < 16 gains lock
`define RFO_AVG_LEN_LOG2   3     // average over 8 phase values

// H-bridge dead time in clock cycles, 0.5 us at 10 MHz
`define RFO_DEAD_CYCLES    5

`endif

/* rfo_cycle_edge.sv */
`timescale 1ns/10ps

module rfo_cycle_edge (
	input  logic clk10MHz_inv,
	input  logic rst_n,
	input  logic osc,           // raw oscillator msb
	output logic osc_q,         // osc registered once
	output logic period_start   // one cycle strobe per period
);

	logic osc_qq;  // second stage, only for the edge compare

	// two-stage shift of the oscillator
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			osc_q  <= 1'b0;
			osc_qq <= 1'b0;
		end else begin
			osc_q  <= osc;
			osc_qq <= osc_q;
		end
	end

	// strobe is high the cycle after osc_q rises
	// no handshake, every consumer takes it in that cycle
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			period_start <= 1'b0;
		end else begin
			period_start <= osc_q & ~osc_qq;  // rising edge of osc_q
		end
	end

endmodule

/* rfo_dead_time.sv */
`timescale 1ns/10ps
`include "rfo_consts.svh"

module rfo_dead_time #(
	parameter int dead_cycles = `RFO_DEAD_CYCLES  // at least 1
) (
	input  logic clk10MHz_inv,
	input  logic rst_n,
	input  logic standby,
	input  logic osc_q,    // registered square wave
	output logic gate_ap,  // leg A high side
	output logic gate_an,  // leg A low side
	output logic gate_bp,  // leg B high side
	output logic gate_bn   // leg B low side
);

	logic [1:0]             drive;     // [0] leg A, [1] leg B
	logic [dead_cycles-1:0] dly [2];   // per leg delay chain
	logic [1:0]             drive_dly; // drive seen dead_cycles ago
	logic [1:0]             gate_p;
	logic [1:0]             gate_n;

	// legs switch in opposition
	assign drive[0] = osc_q;
	assign drive[1] = ~osc_q;

	// shift chains, oldest bit at the top
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			dly[0] <= '0;
			dly[1] <= '0;
		end else begin
			for (int leg = 0; leg < 2; leg++) begin
				for (int j = dead_cycles - 1; j > 0; j--) dly[leg][j] <= dly[leg][j-1];
				dly[leg][0] <= drive[leg];
			end
		end
	end

	assign drive_dly[0] = dly[0][dead_cycles-1];
	assign drive_dly[1] = dly[1][dead_cycles-1];

	// turn-on waits until drive has been steady for dead_cycles
	// turn-off follows drive right away
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			gate_p <= '0;
			gate_n <= '0;
		end else if (standby) begin
			gate_p <= '0;  // bridge fully off
			gate_n <= '0;
		end else begin
			gate_p <= drive & drive_dly;     // both high
			gate_n <= ~(drive | drive_dly);  // both low
		end
	end

	assign gate_ap = gate_p[0];
	assign gate_an = gate_n[0];
	assign gate_bp = gate_p[1];
	assign gate_bn = gate_n[1];

endmodule

/* rfo_ico.sv */
`timescale 1ns/10ps
`include "rfo_consts.svh"

module rfo_ico (
	input  logic           clk10MHz_inv,
	input  logic           rst_n,
	input  rfo_pkg::incr_t increment,  // tuning word from the regulator
	output logic           osc         // switching square wave
);

	import rfo_pkg::*;

	phase_acc_t acc;        // phase accumulator
	phase_acc_t inc_ext;    // increment widened to accumulator size

	// increment sits in the low bits, no sign
	assign inc_ext = phase_acc_t'(increment);

	// wraps modulo 2^24, one period per wrap
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= acc + inc_ext;  // new increment shows up here one cycle later
		end
	end

	// msb gives 50 % duty square wave
	// f_osc = increment * 10e6 / 2^24
	assign osc = acc[`RFO_ACC_W-1];

endmodule

/* rfo_lock_detect.sv */
`timescale 1ns/10ps
`include "rfo_consts.svh"

module rfo_lock_detect (
	input  logic            clk10MHz_inv,
	input  logic            rst_n,
	input  logic            standby,
	input  rfo_pkg::theta_t theta,
	input  logic            theta_valid,
	output logic            locked
);

	import rfo_pkg::*;

	theta_t      hist [0:(1 << `RFO_AVG_LEN_LOG2)-2];  // seven older values
	logic signed [`RFO_THETA_W+`RFO_AVG_LEN_LOG2-1:0] sum;  // no overflow over 8
	theta_t      avg;
	logic [`RFO_THETA_W-1:0] avg_mag;  // |avg|, -512 reads as 512
	lock_state_e state;

	// incoming theta plus seven stored ones make the eight
	always_comb begin
		sum = theta;
		for (int i = 0; i < (1 << `RFO_AVG_LEN_LOG2) - 1; i++) begin
			sum = sum + hist[i];
		end
	end

	assign avg     = theta_t'(sum >>> `RFO_AVG_LEN_LOG2);  // divide by 8
	assign avg_mag = avg[`RFO_THETA_W-1] ? -avg : avg;

	// history shift, newest at index 0
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << `RFO_AVG_LEN_LOG2) - 1; i++) hist[i] <= '0;
		end else if (theta_valid) begin
			hist[0] <= theta;
			for (int i = 1; i < (1 << `RFO_AVG_LEN_LOG2) - 1; i++) hist[i] <= hist[i-1];
		end
	end

	// hysteresis, 16 in and 40 out
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_unlocked;
		end else if (standby) begin
			state <= st_unlocked;  // no lock while the bridge is off
		end else if (theta_valid) begin
			case (state)
				st_unlocked: if (avg_mag < `RFO_LOCK_LOWER)  state <= st_locked;
				st_locked:   if (avg_mag >= `RFO_LOCK_UPPER) state <= st_unlocked;
				default:     state <= st_unlocked;
			endcase
		end
	end

	assign locked = (state == st_locked);

endmodule

/* rfo_phase_meter.sv */
`timescale 1ns/10ps
`include "rfo_consts.svh"

module rfo_phase_meter (
	input  logic            clk10MHz_inv,
	input  logic            rst_n,
	input  logic            iq,            // current polarity, async to us
	input  logic            osc_q,         // registered oscillator
	input  logic            period_start,
	output rfo_pkg::theta_t theta,         // signed phase of the last period
	output logic            theta_valid
);

	import rfo_pkg::*;

	logic [`RFO_SYNC_STAGES-1:0] iq_sync;               // synchroniser chain
	logic                        dl_mem [0:(1 << `RFO_DL_DEPTH_W)-1];
	dl_addr_t                    wr_ptr;
	dl_addr_t                    rd_ptr;
	logic                        iq_dl;                 // iq delayed by sync + tap
	logic signed [`RFO_THETA_W+5:0] corr_cnt;           // wide so a slow period fits
	logic                        cnt_at_max;
	logic                        cnt_at_min;
	theta_t                      theta_hi;
	theta_t                      theta_lo;
	theta_t                      theta_sat;

	// two flops before anything looks at iq
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			iq_sync <= '0;
		end else begin
			iq_sync <= {iq_sync[`RFO_SYNC_STAGES-2:0], iq};
		end
	end

	// free running write pointer
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// delay line storage, written every cycle
	always_ff @(posedge clk10MHz_inv) begin
		dl_mem[wr_ptr] <= iq_sync[`RFO_SYNC_STAGES-1];
	end

	assign rd_ptr = wr_ptr - dl_addr_t'(`RFO_DL_TAP);  // tap entries behind
	assign iq_dl  = dl_mem[rd_ptr];

	// counter limits and theta range
	assign cnt_at_max = (corr_cnt == {1'b0, {(`RFO_THETA_W+5){1'b1}}});
	assign cnt_at_min = (corr_cnt == {1'b1, {(`RFO_THETA_W+5){1'b0}}});
	assign theta_hi   = {1'b0, {(`RFO_THETA_W-1){1'b1}}};  // +511
	assign theta_lo   = {1'b1, {(`RFO_THETA_W-1){1'b0}}};  // -512

	always_comb begin
		if (corr_cnt > theta_hi) begin
			theta_sat = theta_hi;
		end else if (corr_cnt < theta_lo) begin
			theta_sat = theta_lo;
		end else begin
			theta_sat = theta_t'(corr_cnt);
		end
	end

	// match counts up, mismatch counts down, restart each period
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			corr_cnt    <= '0;
			theta_valid <= 1'b0;
		end else begin
			theta_valid <= period_start;  // one cycle behind the strobe
			if (period_start) begin
				corr_cnt <= '0;
			end else if (osc_q == iq_dl) begin
				if (!cnt_at_max) corr_cnt <= corr_cnt + 1'b1;
			end else begin
				if (!cnt_at_min) corr_cnt <= corr_cnt - 1'b1;
			end
		end
	end

	// phase latch, plain data
	always_ff @(posedge clk10MHz_inv) begin
		if (period_start) theta <= theta_sat;  // clamp to +-full scale
	end

endmodule

/* rfo_pi_ctrl.sv */
`timescale 1ns/10ps
`include "rfo_consts.svh"

module rfo_pi_ctrl (
	input  logic            clk10MHz_inv,
	input  logic            rst_n,
	input  logic            standby,
	input  rfo_pkg::theta_t theta,
	input  logic            theta_valid,
	output rfo_pkg::incr_t  increment     // to the oscillator
);

	import rfo_pkg::*;

	integ_t integ;         // integrator, increment plus fraction bits
	integ_t integ_start;   // start point aligned to the integrator
	integ_t integ_sat;     // next value after clamping
	logic signed [`RFO_THETA_W:0]               err;        // theta minus target
	logic signed [`RFO_INC_W+`RFO_PI_FRAC+1:0] step;       // scaled error
	logic signed [`RFO_INC_W+`RFO_PI_FRAC+1:0] integ_sum;  // two guard bits on top

	assign integ_start = integ_t'(`RFO_START_POINT << `RFO_PI_FRAC);

	always_comb begin
		err  = theta - `RFO_THETA_TARGET;      // fits in one extra bit
		step = err;                            // sign extend first
		step = step <<< `RFO_KI_SHIFT;         // ki gain
		// integrator bits read as non-negative
		integ_sum = $signed({2'b00, integ}) + step;
		if (integ_sum[`RFO_INC_W+`RFO_PI_FRAC+1]) begin
			integ_sat = '0;                    // went below zero
		end else if (integ_sum[`RFO_INC_W+`RFO_PI_FRAC]) begin
			integ_sat = '1;                    // past top of incr range
		end else begin
			integ_sat = integ_t'(integ_sum);
		end
	end

	// update once per period, standby parks it at the start point
	always_ff @(posedge clk10MHz_inv or negedge rst_n) begin
		if (!rst_n) begin
			integ <= integ_start;
		end else if (standby) begin
			integ <= integ_start;
		end else if (theta_valid) begin
			integ <= integ_sat;
		end
	end

	// drop the fraction bits
	// new value appears the cycle after theta_valid
	assign increment = integ[`RFO_INC_W+`RFO_PI_FRAC-1:`RFO_PI_FRAC];

endmodule

/* rfo_pkg.sv */
`include "rfo_consts.svh"

package rfo_pkg;

	// signed phase, one value per oscillator period
	typedef logic signed [`RFO_THETA_W-1:0] theta_t;

	// oscillator tuning word
	typedef logic [`RFO_INC_W-1:0] incr_t;

	// accumulator, top bit is the square wave
	typedef logic [`RFO_ACC_W-1:0] phase_acc_t;

	// delay line pointer, wraps freely
	typedef logic [`RFO_DL_DEPTH_W-1:0] dl_addr_t;

	// integrator keeps the increment plus fraction bits
	// bit pattern is treated as a non-negative value by the regulator
	typedef logic signed [`RFO_INC_W+`RFO_PI_FRAC-1:0] integ_t;

	// lock detector states
	typedef enum logic {
		st_unlocked,
		st_locked
	} lock_state_e;

endpackage

/* rfo_top.sv */
`timescale 1ns/10ps

module rfo_top (
	input  logic            clk10MHz_inv,
	input  logic            rst_n,
	input  logic            standby,      // already debounced
	input  logic            iq,           // current polarity comparator
	output logic            osc_out,      // oscillator msb
	output rfo_pkg::theta_t theta,
	output logic            theta_valid,
	output rfo_pkg::incr_t  increment,
	output logic            locked,
	output logic            gate_ap,
	output logic            gate_an,
	output logic            gate_bp,
	output logic            gate_bn
);

	logic osc_q;         // registered square wave
	logic period_start;  // start of each oscillator period

	// oscillator, tuned by the regulator
	rfo_ico i_ico (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.increment    (increment),
		.osc          (osc_out)
	);

	rfo_cycle_edge i_cycle_edge (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.osc          (osc_out),
		.osc_q        (osc_q),
		.period_start (period_start)
	);

	// osc rise to theta_valid is 3 cycles
	rfo_phase_meter i_phase_meter (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.iq           (iq),
		.osc_q        (osc_q),
		.period_start (period_start),
		.theta        (theta),
		.theta_valid  (theta_valid)
	);

	// closes the loop back to the oscillator
	rfo_pi_ctrl i_pi_ctrl (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.standby      (standby),
		.theta        (theta),
		.theta_valid  (theta_valid),
		.increment    (increment)
	);

	rfo_lock_detect i_lock_detect (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.standby      (standby),
		.theta        (theta),
		.theta_valid  (theta_valid),
		.locked       (locked)
	);

	rfo_dead_time i_dead_time (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.standby      (standby),
		.osc_q        (osc_q),
		.gate_ap      (gate_ap),
		.gate_an      (gate_an),
		.gate_bp      (gate_bp),
		.gate_bn      (gate_bn)
	);

endmodule

/* sources.f */
+incdir+.
rfo_pkg.sv
rfo_ico.sv
rfo_cycle_edge.sv
rfo_phase_meter.sv
rfo_pi_ctrl.sv
rfo_lock_detect.sv
rfo_dead_time.sv
rfo_top.sv
tb_rfo_top.sv

/* tb_rfo_top.sv */
`timescale 1ns/10ps
`include "rfo_consts.svh"

module tb_rfo_top;

	import rfo_pkg::*;

	localparam int TIMEOUT_CYCLES = 400 * 1000;  // 400 periods of at most 1000 cycles
	localparam int L_DLY     = `RFO_SYNC_STAGES + `RFO_DL_TAP;  // iq port to correlator
	localparam int INTEG_MAX = (1 << (`RFO_INC_W + `RFO_PI_FRAC)) - 1;
	localparam int TH_MAX    = (1 << (`RFO_THETA_W - 1)) - 1;
	localparam int CNT_MAX   = (1 << (`RFO_THETA_W + 5)) - 1;  // counter never gets near this

	logic   clk10MHz_inv;
	logic   rst_n;
	logic   standby;
	logic   iq;
	logic   osc_out;
	theta_t theta;
	logic   theta_valid;
	incr_t  increment;
	logic   locked;
	logic   gate_ap;
	logic   gate_an;
	logic   gate_bp;
	logic   gate_bn;

	// stimulus side
	int          iq_delay;          // iq lags osc_out by this many cycles
	logic        glitch_on;
	logic        stby_drv;
	int          drv_cyc;
	int          periods_seen;
	logic        osc_trail [0:255];
	int unsigned seed_val;

	// model state updated on the falling edge
	logic       rst_s, stby_s, iq_s;  // inputs as seen by the last rising edge
	int         cyc, since_rst, tmo_cyc;
	logic       ohist [0:255];        // osc_out per cycle
	logic       iq_hist [0:63];       // iq per rising edge
	phase_acc_t acc_m;
	int         cnt_m, integ_m;
	logic       cnt_known, st_m;
	int         hist_m [0:6];         // seven older theta values with the newest at index 0
	incr_t      inc_prev;
	theta_t     theta_prev;
	logic       tv_prev, locked_prev;
	int         lock_ups, lock_downs;
	int         err_theta, err_incr, err_bit, err_other;

	rfo_top i_dut (
		.clk10MHz_inv (clk10MHz_inv),
		.rst_n        (rst_n),
		.standby      (standby),
		.iq           (iq),
		.osc_out      (osc_out),
		.theta        (theta),
		.theta_valid  (theta_valid),
		.increment    (increment),
		.locked       (locked),
		.gate_ap      (gate_ap),
		.gate_an      (gate_an),
		.gate_bp      (gate_bp),
		.gate_bn      (gate_bn)
	);

	initial begin
		clk10MHz_inv = 1'b0;
		forever #50 clk10MHz_inv = ~clk10MHz_inv;  // 10 MHz
	end

	// reference models
	function automatic phase_acc_t acc_next(input phase_acc_t acc, input incr_t inc);
		return acc + phase_acc_t'(inc);  // wraps mod 2^24
	endfunction

	function automatic int cnt_next(input int cnt, input logic match);
		if (match) return (cnt < CNT_MAX) ? cnt + 1 : cnt;
		return (cnt > -CNT_MAX - 1) ? cnt - 1 : cnt;
	endfunction

	function automatic theta_t sat_theta(input int cnt);
		if (cnt > TH_MAX) return theta_t'(TH_MAX);
		if (cnt < -TH_MAX - 1) return theta_t'(-TH_MAX - 1);
		return theta_t'(cnt);
	endfunction

	function automatic int pi_next(input int integ, input int th, input logic tv, input logic stby);
		int s;
		if (stby) return `RFO_START_POINT << `RFO_PI_FRAC;  // reload
		if (!tv) return integ;
		s = integ + (th - `RFO_THETA_TARGET) * (1 << `RFO_KI_SHIFT);
		if (s < 0) return 0;
		if (s > INTEG_MAX) return INTEG_MAX;
		return s;
	endfunction

	function automatic int avg_magnitude(input int sum);
		int avg;
		avg = sum >>> `RFO_AVG_LEN_LOG2;  // floor of sum / 8
		return (avg < 0) ? -avg : avg;
	endfunction

	function automatic logic lock_next(input logic st, input int mag);
		if (st) return !(mag >= `RFO_LOCK_UPPER);
		return mag < `RFO_LOCK_LOWER;
	endfunction

	// {ap, an, bp, bn} from drive now and drive dead_cycles ago
	function automatic logic [3:0] gates_exp(input logic a, input logic a_d, input logic stby);
		if (stby) return 4'b0000;
		return {a & a_d, ~a & ~a_d, ~a & ~a_d, a & a_d};
	endfunction

	task automatic check_theta(input string name, input theta_t act, input theta_t exp);
		if (act !== exp) begin
			err_theta++;
			$display("error at %0t ns: %s expected %0d, actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_incr(input string name, input incr_t act, input incr_t exp);
		if (act !== exp) begin
			err_incr++;
			$display("error at %0t ns: %s expected %0d, actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			err_bit++;
			$display("error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
		end
	endtask

	initial begin
		for (int i = 0; i < 256; i++) ohist[i] = 1'b0;
		for (int i = 0; i < 64; i++) iq_hist[i] = 1'b0;
		rst_s = 1'b0;
		stby_s = 1'b1;
		iq_s = 1'b0;
		cyc = 0;
		err_theta = 0;
		err_incr = 0;
		err_bit = 0;
		err_other = 0;
		lock_ups = 0;
		lock_downs = 0;
		locked_prev = 1'b0;
	end

	// inputs settled half a cycle before this edge
	always @(posedge clk10MHz_inv) begin
		rst_s  = rst_n;
		stby_s = standby;
		iq_s   = iq;
	end

	always @(negedge clk10MHz_inv) begin : compare
		logic       ps;
		logic [3:0] g;
		int         sum;
		cyc = cyc + 1;
		ohist[cyc & 255] = osc_out;
		iq_hist[cyc & 63] = iq_s;
		if (!rst_s) begin
			acc_m = '0;
			cnt_m = 0;
			cnt_known = 1'b0;
			integ_m = `RFO_START_POINT << `RFO_PI_FRAC;
			st_m = 1'b0;
			since_rst = 0;
			for (int i = 0; i < 7; i++) hist_m[i] = 0;
			check_bit("osc_out", osc_out, 1'b0);
			check_bit("theta_valid", theta_valid, 1'b0);
			check_incr("increment", increment, incr_t'(`RFO_START_POINT));
			check_bit("locked", locked, 1'b0);
			check_bit("gate_ap", gate_ap, 1'b0);
			check_bit("gate_an", gate_an, 1'b0);
			check_bit("gate_bp", gate_bp, 1'b0);
			check_bit("gate_bn", gate_bn, 1'b0);
		end else begin
			since_rst++;
			acc_m = acc_next(acc_m, inc_prev);
			check_bit("osc_out", osc_out, acc_m[`RFO_ACC_W-1]);
			// registered osc rose one cycle before this edge
			ps = ohist[(cyc - 3) & 255] & ~ohist[(cyc - 4) & 255];
			check_bit("theta_valid", theta_valid, ps);
			if (ps) begin
				if (cnt_known) check_theta("theta", theta, sat_theta(cnt_m));
				cnt_m = 0;
				cnt_known = (since_rst >= L_DLY + 6);  // delay line filled by then
			end else begin
				cnt_m = cnt_next(cnt_m, ohist[(cyc - 2) & 255] == iq_hist[(cyc - L_DLY) & 63]);
			end
			integ_m = pi_next(integ_m, int'(theta_prev), tv_prev, stby_s);
			check_incr("increment", increment, incr_t'(integ_m >> `RFO_PI_FRAC));
			sum = int'(theta_prev);
			for (int i = 0; i < 7; i++) sum = sum + hist_m[i];
			if (stby_s) st_m = 1'b0;
			else if (tv_prev) st_m = lock_next(st_m, avg_magnitude(sum));
			if (tv_prev) begin  // history shifts in standby as well
				for (int i = 6; i > 0; i--) hist_m[i] = hist_m[i-1];
				hist_m[0] = int'(theta_prev);
			end
			check_bit("locked", locked, st_m);
			if (stby_s || since_rst > `RFO_DEAD_CYCLES) begin
				g = gates_exp(ohist[(cyc - 2) & 255],
					ohist[(cyc - 2 - `RFO_DEAD_CYCLES) & 255], stby_s);
				check_bit("gate_ap", gate_ap, g[3]);
				check_bit("gate_an", gate_an, g[2]);
				check_bit("gate_bp", gate_bp, g[1]);
				check_bit("gate_bn", gate_bn, g[0]);
			end
			if (gate_ap && gate_an) begin
				err_other++;
				$display("both gates of leg A are on at %0t ns", $time);
			end
			if (gate_bp && gate_bn) begin
				err_other++;
				$display("both gates of leg B are on at %0t ns", $time);
			end
		end
		if (locked === 1'b1 && locked_prev === 1'b0) lock_ups++;
		if (locked === 1'b0 && locked_prev === 1'b1) lock_downs++;
		locked_prev = locked;
		inc_prev = increment;
		theta_prev = theta;
		tv_prev = theta_valid;
	end

	// iq follows osc_out after a delay with rare glitches added
	task step_cycle;
		logic glitch;
		@(negedge clk10MHz_inv);
		drv_cyc = drv_cyc + 1;
		osc_trail[drv_cyc & 255] = osc_out;
		glitch = glitch_on && (($urandom % 150) == 0);
		iq = osc_trail[(drv_cyc - iq_delay) & 255] ^ glitch;
		standby = stby_drv;
		if (theta_valid) periods_seen++;
	endtask

	task run_cycles(input int n);
		repeat (n) step_cycle();
	endtask

	task run_periods(input int n);
		periods_seen = 0;
		while (periods_seen < n) step_cycle();
	endtask

	initial begin : stimulus
		int per;
		rst_n = 1'b0;
		standby = 1'b1;
		iq = 1'b0;
		stby_drv = 1'b1;
		iq_delay = 0;
		glitch_on = 1'b0;
		drv_cyc = 0;
		periods_seen = 0;
		for (int i = 0; i < 256; i++) osc_trail[i] = 1'b0;
		seed_val = $urandom(61339);
		repeat (2) @(negedge clk10MHz_inv);
		rst_n = 1'b1;
		run_cycles(300);  // bridge off in standby
		stby_drv = 1'b0;
		glitch_on = 1'b1;
		for (int k = 0; k < 8; k++) begin
			if (k % 2 == 0) begin
				iq_delay = $urandom % 61;  // far from target so lock drops
			end else begin
				// delay that puts theta near target at the present period
				per = (1 << `RFO_ACC_W) / ((increment == 0) ? 1 : int'(increment));
				iq_delay = (per - `RFO_THETA_TARGET) / 4 - (L_DLY - 1) + int'($urandom % 5) - 2;
				if (iq_delay < 0) iq_delay = 0;
				if (iq_delay > 250) iq_delay = 250;
			end
			run_periods(24);
			if (k == 3) begin
				stby_drv = 1'b1;  // reload check mid run
				run_periods(3);
				stby_drv = 1'b0;
			end
		end
		@(posedge clk10MHz_inv);
		$display("lock gained %0d times, lost %0d times", lock_ups, lock_downs);
		if (lock_ups == 0 || lock_downs == 0) begin
			err_other++;
			$display("lock detector was not driven across both thresholds by the delay sweep");
		end
		$display("error counts: theta %0d, increment %0d, bit %0d, other %0d",
			err_theta, err_incr, err_bit, err_other);
		if (err_theta + err_incr + err_bit + err_other == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		tmo_cyc = 0;
		while (tmo_cyc < TIMEOUT_CYCLES) begin
			@(posedge clk10MHz_inv);
			tmo_cyc++;
		end
		$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("error counts: theta %0d, increment %0d, bit %0d, other %0d",
			err_theta, err_incr, err_bit, err_other);
		$display("tests failed");
		$finish;
	end

endmodule
